// File: src/sd_cmd_pkg.sv
/* Frame constants, field positions and state encodings of the SD command path.
   RTL and testbench reference these by scoped name */
package sd_cmd_pkg;

	// Command and response frames are both 48 bits
	localparam int FRAME_BITS = 48;
	localparam int CMD_WORD_BITS = 38;

	// Start, direction, index and argument come ahead of the CRC
	localparam int HDR_BITS = 40;
	localparam int CRC_BITS = 7;

	// Fields of the index plus argument word
	localparam int IDX_MSB = 37;
	localparam int IDX_LSB = 32;
	localparam int ARG_MSB = 31;
	localparam int ARG_LSB = 0;

	// Word sits above the CRC and end bit inside a frame
	localparam int WORD_OFS = 8;
	localparam int STATUS_MSB = ARG_MSB + WORD_OFS;
	localparam int STATUS_LSB = ARG_LSB + WORD_OFS;

	typedef enum logic [1:0] {
		st_waiting_cmd,
		st_setup,
		st_waiting_response,
		st_finishing
	} master_state_e;

	typedef enum logic [2:0] {
		ph_idle,
		ph_ack,
		ph_send,
		ph_receive,
		ph_report
	} phy_state_e;

	typedef enum logic [1:0] {
		rx_idle,
		rx_hunt,
		rx_shift,
		rx_done
	} rx_state_e;

endpackage

// File: src/cmd_crc7.sv
/* Serial CRC7 (x^7 + x^3 + 1) over outgoing command bits, MSB first.
   Cleared before each frame and advanced once per transmitted bit */
`timescale 1ns/10ps

module cmd_crc7 (
	input  logic                            rst,
	input  logic                            CLK_host,
	input  logic                            clear,
	input  logic                            bit_en,
	input  logic                            data_bit,
	output logic [sd_cmd_pkg::CRC_BITS-1:0] crc
);

	logic feedback;

	assign feedback = data_bit ^ crc[sd_cmd_pkg::CRC_BITS-1];

	always_ff @(posedge CLK_host) begin
		if (rst || clear) begin
			crc <= '0;
		end else if (bit_en) begin
			// Taps at x^3 and x^0
			crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
		end
	end

endmodule

// File: src/cmd_response_rx.sv
/* Response receiver. Hunts for the card's start bit for up to TIMEOUT_BITS
   bit periods, then shifts in a 48-bit frame and holds it until the next start */
`timescale 1ns/10ps

module cmd_response_rx #(
	parameter int TIMEOUT_BITS = 64
) (
	input  logic                              rst,
	input  logic                              CLK_host,
	input  logic                              start,
	input  logic                              bit_en,
	input  logic                              cmd_in,
	input  logic                              abort,
	output logic                              done,
	output logic                              timeout,
	output logic [sd_cmd_pkg::FRAME_BITS-1:0] response
);

	localparam int WAIT_W = $clog2(TIMEOUT_BITS + 1);

	sd_cmd_pkg::rx_state_e state_q;
	logic [WAIT_W-1:0] wait_cnt;
	logic [5:0] bit_cnt;
	logic last_bit;
	logic expired;
	logic take_bit;

	assign last_bit = bit_cnt == 6'(sd_cmd_pkg::FRAME_BITS - 1);
	assign expired = wait_cnt == WAIT_W'(TIMEOUT_BITS - 1);

	// Both pulses fall on the bit_en that decides them
	assign done = state_q == sd_cmd_pkg::rx_shift && bit_en && last_bit;
	assign timeout = state_q == sd_cmd_pkg::rx_hunt && bit_en && cmd_in && expired;

	// Start bit is the first bit of the frame
	assign take_bit = bit_en && (state_q == sd_cmd_pkg::rx_shift ||
		(state_q == sd_cmd_pkg::rx_hunt && !cmd_in));

	always_ff @(posedge CLK_host) begin
		if (rst || abort) begin
			state_q <= sd_cmd_pkg::rx_idle;
		end else begin
			case (state_q)
				sd_cmd_pkg::rx_idle: begin
					if (start) begin
						state_q <= sd_cmd_pkg::rx_hunt;
					end
				end
				sd_cmd_pkg::rx_hunt: begin
					if (bit_en && !cmd_in) begin
						state_q <= sd_cmd_pkg::rx_shift;
					end else if (timeout) begin
						state_q <= sd_cmd_pkg::rx_idle;
					end
				end
				sd_cmd_pkg::rx_shift: begin
					if (done) begin
						state_q <= sd_cmd_pkg::rx_done;
					end
				end
				default: begin
					state_q <= sd_cmd_pkg::rx_idle;
				end
			endcase
		end
	end

	// bit_cnt starts at 1 since the start bit is taken during the hunt
	always_ff @(posedge CLK_host) begin
		if (rst || state_q == sd_cmd_pkg::rx_idle) begin
			wait_cnt <= '0;
			bit_cnt <= 6'd1;
		end else if (bit_en) begin
			if (state_q == sd_cmd_pkg::rx_hunt) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
			if (state_q == sd_cmd_pkg::rx_shift) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_host) begin
		if (take_bit) begin
			response <= {response[sd_cmd_pkg::FRAME_BITS-2:0], cmd_in};
		end
	end

endmodule

// File: src/cmd_physical.sv
/* Command physical layer. Frames the 38-bit word with start, direction, CRC7
   and end bits, sends it on CMD at one bit per CLK_DIV cycles, then receives the reply */
`timescale 1ns/10ps

module cmd_physical #(
	parameter int CLK_DIV = 4,
	parameter int TIMEOUT_BITS = 64
) (
	input  logic                                 rst,
	input  logic                                 CLK_host,
	input  logic                                 cmd_enable,
	input  logic                                 REQ_out,
	input  logic                                 ACK_out,
	input  logic                                 cmd_in,
	input  logic [sd_cmd_pkg::CMD_WORD_BITS-1:0] cmd_to_physical,
	output logic                                 ACK_in,
	output logic                                 REQ_in,
	output logic                                 timeout_error_from_physical,
	output logic                                 physical_inactive,
	output logic                                 cmd_out,
	output logic                                 cmd_oe,
	output logic [sd_cmd_pkg::FRAME_BITS-1:0]    cmd_response
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int HDR = sd_cmd_pkg::HDR_BITS;

	sd_cmd_pkg::phy_state_e state_q;
	logic [DIV_W-1:0] div_cnt;
	logic bit_en;
	logic [5:0] bit_idx;
	logic [HDR-1:0] tx_hdr;
	logic [sd_cmd_pkg::CRC_BITS-1:0] crc;
	logic [2:0] crc_pos;
	logic crc_en;
	logic last_tx_bit;
	logic tx_bit;
	logic rx_start;
	logic rx_done;
	logic rx_timeout;

	assign physical_inactive = !cmd_enable;

	// Bit clock runs through send and receive without a restart
	assign bit_en = (state_q == sd_cmd_pkg::ph_send || state_q == sd_cmd_pkg::ph_receive) &&
		div_cnt == DIV_W'(CLK_DIV - 1);

	assign last_tx_bit = bit_idx == 6'(sd_cmd_pkg::FRAME_BITS - 1);
	assign rx_start = state_q == sd_cmd_pkg::ph_send && bit_en && last_tx_bit;
	assign crc_en = state_q == sd_cmd_pkg::ph_send && bit_en && bit_idx < 6'(HDR);

	// Frame bit 40 carries crc[6], bit 46 carries crc[0]
	assign crc_pos = 3'(6'(sd_cmd_pkg::FRAME_BITS - 2) - bit_idx);

	always_comb begin
		if (bit_idx < 6'(HDR)) begin
			tx_bit = tx_hdr[HDR-1];
		end else if (last_tx_bit) begin
			tx_bit = 1'b1;
		end else begin
			tx_bit = crc[crc_pos];
		end
	end

	assign ACK_in = state_q == sd_cmd_pkg::ph_ack;
	assign REQ_in = state_q == sd_cmd_pkg::ph_report;
	assign cmd_oe = state_q == sd_cmd_pkg::ph_send;
	assign cmd_out = cmd_oe ? tx_bit : 1'b1;
	assign timeout_error_from_physical = state_q == sd_cmd_pkg::ph_receive && rx_timeout;

	always_ff @(posedge CLK_host) begin
		if (rst || physical_inactive) begin
			state_q <= sd_cmd_pkg::ph_idle;
		end else begin
			case (state_q)
				sd_cmd_pkg::ph_idle: begin
					if (REQ_out) begin
						state_q <= sd_cmd_pkg::ph_ack;
					end
				end
				sd_cmd_pkg::ph_ack: begin
					state_q <= sd_cmd_pkg::ph_send;
				end
				sd_cmd_pkg::ph_send: begin
					if (rx_start) begin
						state_q <= sd_cmd_pkg::ph_receive;
					end
				end
				sd_cmd_pkg::ph_receive: begin
					if (rx_done) begin
						state_q <= sd_cmd_pkg::ph_report;
					end else if (rx_timeout) begin
						state_q <= sd_cmd_pkg::ph_idle;
					end
				end
				sd_cmd_pkg::ph_report: begin
					if (ACK_out) begin
						state_q <= sd_cmd_pkg::ph_idle;
					end
				end
				default: begin
					state_q <= sd_cmd_pkg::ph_idle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK_host) begin
		if (rst || !(state_q == sd_cmd_pkg::ph_send || state_q == sd_cmd_pkg::ph_receive)) begin
			div_cnt <= '0;
		end else if (bit_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK_host) begin
		if (rst || state_q == sd_cmd_pkg::ph_ack) begin
			bit_idx <= '0;
		end else if (state_q == sd_cmd_pkg::ph_send && bit_en) begin
			bit_idx <= bit_idx + 1'b1;
		end
	end

	// Header loads with start bit 0 and direction bit 1 ahead of the word
	always_ff @(posedge CLK_host) begin
		if (state_q == sd_cmd_pkg::ph_idle && REQ_out) begin
			tx_hdr <= {1'b0, 1'b1, cmd_to_physical};
		end else if (state_q == sd_cmd_pkg::ph_send && bit_en) begin
			tx_hdr <= {tx_hdr[HDR-2:0], 1'b0};
		end
	end

	cmd_crc7 u_crc7 (
		.rst      (rst),
		.CLK_host (CLK_host),
		.clear    (state_q == sd_cmd_pkg::ph_ack),
		.bit_en   (crc_en),
		.data_bit (tx_hdr[HDR-1]),
		.crc      (crc)
	);

	// Receiver holds the frame, which stays stable while REQ_in is high
	cmd_response_rx #(
		.TIMEOUT_BITS (TIMEOUT_BITS)
	) u_response_rx (
		.rst      (rst),
		.CLK_host (CLK_host),
		.start    (rx_start),
		.bit_en   (bit_en),
		.cmd_in   (cmd_in),
		.abort    (physical_inactive),
		.done     (rx_done),
		.timeout  (rx_timeout),
		.response (cmd_response)
	);

endmodule

// File: src/cmd_master.sv
/* Host-side command sequencer. Passes index and argument to cmd_physical over
   REQ/ACK, then reports either the response status or a timeout */
`timescale 1ns/10ps

module cmd_master (
	input  logic                                 rst,
	input  logic                                 CLK_host,
	input  logic                                 new_cmd,
	input  logic                                 ACK_in,
	input  logic                                 REQ_in,
	input  logic                                 physical_inactive,
	input  logic [31:0]                          cmd_arg,
	input  logic [5:0]                           cmd_index,
	input  logic [sd_cmd_pkg::FRAME_BITS-1:0]    cmd_response,
	input  logic                                 timeout_error_from_physical,
	output logic                                 cmd_busy,
	output logic                                 cmd_complete,
	output logic                                 REQ_out,
	output logic                                 ACK_out,
	output logic                                 timeout_error,
	output logic [31:0]                          response_status,
	output logic [sd_cmd_pkg::CMD_WORD_BITS-1:0] cmd_to_physical
);

	sd_cmd_pkg::master_state_e state_q;
	sd_cmd_pkg::master_state_e state_d;

	// Outcome of the last command, held through st_finishing
	logic timed_out_q;
	logic [31:0] status_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			sd_cmd_pkg::st_waiting_cmd: begin
				if (new_cmd) begin
					state_d = sd_cmd_pkg::st_setup;
				end
			end
			sd_cmd_pkg::st_setup: begin
				if (ACK_in) begin
					state_d = sd_cmd_pkg::st_waiting_response;
				end
			end
			sd_cmd_pkg::st_waiting_response: begin
				if (REQ_in || timeout_error_from_physical) begin
					state_d = sd_cmd_pkg::st_finishing;
				end
			end
			default: begin
				state_d = sd_cmd_pkg::st_waiting_cmd;
			end
		endcase
	end

	always_ff @(posedge CLK_host) begin
		if (rst || physical_inactive) begin
			state_q <= sd_cmd_pkg::st_waiting_cmd;
		end else begin
			state_q <= state_d;
		end
	end

	// Word is captured once per command and held while REQ_out is up
	always_ff @(posedge CLK_host) begin
		if (state_q == sd_cmd_pkg::st_waiting_cmd && new_cmd) begin
			cmd_to_physical[sd_cmd_pkg::IDX_MSB:sd_cmd_pkg::IDX_LSB] <= cmd_index;
			cmd_to_physical[sd_cmd_pkg::ARG_MSB:sd_cmd_pkg::ARG_LSB] <= cmd_arg;
		end
	end

	// A response takes priority over a timeout in the same cycle
	always_ff @(posedge CLK_host) begin
		if (rst) begin
			timed_out_q <= 1'b0;
		end else if (state_q == sd_cmd_pkg::st_waiting_response) begin
			if (REQ_in) begin
				timed_out_q <= 1'b0;
			end else if (timeout_error_from_physical) begin
				timed_out_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_host) begin
		if (state_q == sd_cmd_pkg::st_waiting_response) begin
			if (REQ_in) begin
				status_q <= cmd_response[sd_cmd_pkg::STATUS_MSB:sd_cmd_pkg::STATUS_LSB];
			end else if (timeout_error_from_physical) begin
				status_q <= '0;
			end
		end
	end

	assign cmd_busy = state_q != sd_cmd_pkg::st_waiting_cmd;
	assign REQ_out = state_q == sd_cmd_pkg::st_setup;
	assign ACK_out = state_q == sd_cmd_pkg::st_waiting_response && REQ_in;
	assign cmd_complete = state_q == sd_cmd_pkg::st_finishing && !timed_out_q;
	assign timeout_error = state_q == sd_cmd_pkg::st_finishing && timed_out_q;
	assign response_status = status_q;

endmodule

// File: src/sd_cmd_top.sv
/* Top level of the SD command path. Joins cmd_master and cmd_physical
   and brings out the host interface and the CMD line pins */
`timescale 1ns/10ps

module sd_cmd_top #(
	parameter int CLK_DIV = 4,
	parameter int TIMEOUT_BITS = 64
) (
	input  logic        rst,
	input  logic        CLK_host,
	input  logic        cmd_enable,
	input  logic        new_cmd,
	input  logic        cmd_in,
	input  logic [5:0]  cmd_index,
	input  logic [31:0] cmd_arg,
	output logic        cmd_busy,
	output logic        cmd_complete,
	output logic        timeout_error,
	output logic        cmd_out,
	output logic        cmd_oe,
	output logic [31:0] response_status
);

	// Master to physical handshake
	logic REQ_out;
	logic ACK_out;
	logic ACK_in;
	logic REQ_in;
	logic timeout_error_from_physical;
	logic physical_inactive;
	logic [sd_cmd_pkg::CMD_WORD_BITS-1:0] cmd_to_physical;
	logic [sd_cmd_pkg::FRAME_BITS-1:0] cmd_response;

	cmd_master u_master (
		.rst                         (rst),
		.CLK_host                    (CLK_host),
		.new_cmd                     (new_cmd),
		.ACK_in                      (ACK_in),
		.REQ_in                      (REQ_in),
		.physical_inactive           (physical_inactive),
		.cmd_arg                     (cmd_arg),
		.cmd_index                   (cmd_index),
		.cmd_response                (cmd_response),
		.timeout_error_from_physical (timeout_error_from_physical),
		.cmd_busy                    (cmd_busy),
		.cmd_complete                (cmd_complete),
		.REQ_out                     (REQ_out),
		.ACK_out                     (ACK_out),
		.timeout_error               (timeout_error),
		.response_status             (response_status),
		.cmd_to_physical             (cmd_to_physical)
	);

	cmd_physical #(
		.CLK_DIV      (CLK_DIV),
		.TIMEOUT_BITS (TIMEOUT_BITS)
	) u_physical (
		.rst                         (rst),
		.CLK_host                    (CLK_host),
		.cmd_enable                  (cmd_enable),
		.REQ_out                     (REQ_out),
		.ACK_out                     (ACK_out),
		.cmd_in                      (cmd_in),
		.cmd_to_physical             (cmd_to_physical),
		.ACK_in                      (ACK_in),
		.REQ_in                      (REQ_in),
		.timeout_error_from_physical (timeout_error_from_physical),
		.physical_inactive           (physical_inactive),
		.cmd_out                     (cmd_out),
		.cmd_oe                      (cmd_oe),
		.cmd_response                (cmd_response)
	);

endmodule

// File: verification/sd_card_model.sv
/* Behavioral SD card for the command path testbench. Captures each command
   frame off the CMD line, checks it against the expected fields and answers */
`timescale 1ns/10ps

module sd_card_model #(
	parameter int CLK_DIV = 4
) (
	input  logic        CLK_host,
	input  logic        rst,
	input  logic        cmd_line,
	input  logic [5:0]  exp_index,
	input  logic [31:0] exp_arg,
	input  logic        reply_en,
	input  int          reply_delay,
	input  logic        corrupt,
	output logic        drive_en,
	output logic        drive_bit,
	output int          frames_seen,
	output int          frames_bad
);

	localparam logic [31:0] STATUS_MASK = 32'hA5A5_5A5A;

	logic [47:0] rx_frame;
	logic frame_ok;

	// SD CRC7, x^7 + x^3 + 1, MSB first
	function automatic logic [6:0] crc7_of(input logic [39:0] bits);
		logic [6:0] crc;
		logic fb;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return crc;
	endfunction

	function automatic logic frame_is_good(input logic [47:0] f);
		return f[47] === 1'b0 && f[46] === 1'b1 && f[45:40] === exp_index &&
			f[39:8] === exp_arg && f[7:1] === crc7_of(f[47:8]) && f[0] === 1'b1;
	endfunction

	// Start bit already seen, rest sampled at the same offset of each bit period
	task automatic capture_frame(output logic [47:0] f);
		f[47] = cmd_line;
		for (int i = 46; i >= 0; i--) begin
			repeat (CLK_DIV) @(negedge CLK_host);
			f[i] = cmd_line;
		end
	endtask

	task automatic send_response(input logic [47:0] cmd_frame);
		logic [47:0] resp;
		resp[47:40] = {2'b00, cmd_frame[45:40]};
		resp[39:8] = cmd_frame[39:8] ^ STATUS_MASK;
		resp[7:1] = crc7_of(resp[47:8]);
		resp[0] = 1'b1;
		// End bit finishes first, then the turnaround delay
		repeat (CLK_DIV * (reply_delay + 1)) @(negedge CLK_host);
		for (int i = 47; i >= 0; i--) begin
			drive_bit = resp[i];
			drive_en = 1'b1;
			repeat (CLK_DIV) @(negedge CLK_host);
		end
		drive_en = 1'b0;
		drive_bit = 1'b1;
	endtask

	initial begin
		drive_en = 1'b0;
		drive_bit = 1'b1;
		frames_seen = 0;
		frames_bad = 0;
		forever begin
			@(negedge CLK_host);
			if (!rst && cmd_line === 1'b0) begin
				capture_frame(rx_frame);
				frames_seen++;
				frame_ok = frame_is_good(rx_frame);
				if (!frame_ok) begin
					frames_bad++;
				end
				// Corrupt rows behave as if the CRC had failed
				if (frame_ok && reply_en && !corrupt) begin
					send_response(rx_frame);
				end
			end
		end
	end

endmodule

// File: verification/sd_cmd_sva.sv
/* Concurrent checks on cmd_master, attached to every instance through bind */
`timescale 1ns/10ps

module cmd_master_sva (
	input logic                                 CLK_host,
	input logic                                 rst,
	input logic                                 cmd_busy,
	input logic                                 cmd_complete,
	input logic                                 timeout_error,
	input logic                                 REQ_out,
	input logic [sd_cmd_pkg::CMD_WORD_BITS-1:0] cmd_to_physical
);

	a_one_outcome: assert property (@(posedge CLK_host) disable iff (rst)
		!(cmd_complete && timeout_error))
		else $error("cmd_complete and timeout_error high together");

	a_req_busy: assert property (@(posedge CLK_host) disable iff (rst)
		REQ_out |-> cmd_busy)
		else $error("REQ_out high while cmd_busy low");

	a_complete_pulse: assert property (@(posedge CLK_host) disable iff (rst)
		cmd_complete |=> !cmd_complete)
		else $error("cmd_complete longer than one cycle");

	// Word must not move under a pending request
	a_word_stable: assert property (@(posedge CLK_host) disable iff (rst)
		REQ_out |=> !REQ_out || $stable(cmd_to_physical))
		else $error("cmd_to_physical changed while REQ_out high");

endmodule

bind cmd_master cmd_master_sva u_sva (
	.CLK_host        (CLK_host),
	.rst             (rst),
	.cmd_busy        (cmd_busy),
	.cmd_complete    (cmd_complete),
	.timeout_error   (timeout_error),
	.REQ_out         (REQ_out),
	.cmd_to_physical (cmd_to_physical)
);

// File: verification/sd_cmd_tb.sv
/* Table-driven testbench for sd_cmd_top. Each row sends one command to the
   card model and checks the outcome, then a closing line gives the counts */
`timescale 1ns/10ps

module sd_cmd_tb;

	localparam int CLK_DIV = 4;
	localparam int TIMEOUT_BITS = 64;
	localparam int NUM_ROWS = 9;
	localparam int SEED = 99881;
	localparam logic [31:0] STATUS_MASK = 32'hA5A5_5A5A;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * (48 + 64 + 48 + 16) * CLK_DIV + 100;

	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] arg;
		logic        random_arg;
		logic        reply;
		logic [7:0]  delay;
		logic        corrupt;
		logic        enable_held;
		logic        restrobe;
		logic        expect_complete;
	} row_t;

	logic CLK_host;
	logic rst;
	logic cmd_enable;
	logic new_cmd;
	logic [5:0] cmd_index;
	logic [31:0] cmd_arg;
	logic cmd_busy;
	logic cmd_complete;
	logic timeout_error;
	logic cmd_out;
	logic cmd_oe;
	logic [31:0] response_status;
	wire cmd_line;

	// Card model side
	logic [5:0] exp_index;
	logic [31:0] exp_arg;
	logic reply_en;
	int reply_delay;
	logic corrupt;
	logic card_drive_en;
	logic card_drive_bit;
	int frames_seen;
	int frames_bad;

	row_t rows [NUM_ROWS];
	int error_count;
	int tests_run;
	int tests_failed;
	int seed_value;

	assign cmd_line = cmd_oe ? cmd_out : 1'bz;
	assign cmd_line = card_drive_en ? card_drive_bit : 1'bz;
	pullup (cmd_line);

	sd_cmd_top #(
		.CLK_DIV      (CLK_DIV),
		.TIMEOUT_BITS (TIMEOUT_BITS)
	) u_dut (
		.rst             (rst),
		.CLK_host        (CLK_host),
		.cmd_enable      (cmd_enable),
		.new_cmd         (new_cmd),
		.cmd_in          (cmd_line),
		.cmd_index       (cmd_index),
		.cmd_arg         (cmd_arg),
		.cmd_busy        (cmd_busy),
		.cmd_complete    (cmd_complete),
		.timeout_error   (timeout_error),
		.cmd_out         (cmd_out),
		.cmd_oe          (cmd_oe),
		.response_status (response_status)
	);

	sd_card_model #(
		.CLK_DIV (CLK_DIV)
	) u_card (
		.CLK_host    (CLK_host),
		.rst         (rst),
		.cmd_line    (cmd_line),
		.exp_index   (exp_index),
		.exp_arg     (exp_arg),
		.reply_en    (reply_en),
		.reply_delay (reply_delay),
		.corrupt     (corrupt),
		.drive_en    (card_drive_en),
		.drive_bit   (card_drive_bit),
		.frames_seen (frames_seen),
		.frames_bad  (frames_bad)
	);

	initial begin
		CLK_host = 1'b0;
		forever #50 CLK_host = ~CLK_host;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_host);
		$display("Watchdog expired before all rows finished");
		$display("TB FAILED");
		$finish;
	end

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	task automatic set_row(input int n, input logic [5:0] index, input logic [31:0] arg,
		input logic random_arg, input logic reply, input logic [7:0] delay,
		input logic corrupt_frame, input logic enable_held, input logic restrobe,
		input logic expect_complete);
		rows[n].index = index;
		rows[n].arg = arg;
		rows[n].random_arg = random_arg;
		rows[n].reply = reply;
		rows[n].delay = delay;
		rows[n].corrupt = corrupt_frame;
		rows[n].enable_held = enable_held;
		rows[n].restrobe = restrobe;
		rows[n].expect_complete = expect_complete;
	endtask

	task automatic load_table();
		// row, index, arg, random, reply, delay, corrupt, enable, restrobe, complete
		set_row(0, 6'd0,  32'h0000_0000, 0, 1, 2, 0, 1, 0, 1);
		set_row(1, 6'd17, 32'h0000_0200, 0, 1, 5, 0, 1, 0, 1);
		set_row(2, 6'd55, 32'h0,         1, 1, 1, 0, 1, 0, 1);
		set_row(3, 6'd8,  32'h0,         1, 1, 9, 0, 1, 0, 1);
		set_row(4, 6'd13, 32'h1234_5678, 0, 0, 0, 0, 1, 0, 0);
		set_row(5, 6'd24, 32'h0,         1, 1, 2, 1, 1, 0, 0);
		set_row(6, 6'd41, 32'hDEAD_BEEF, 0, 1, 3, 0, 1, 1, 1);
		set_row(7, 6'd12, 32'h0F0F_0F0F, 0, 0, 0, 0, 0, 0, 0);
		set_row(8, 6'd63, 32'h0,         1, 1, 4, 0, 1, 0, 1);
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].random_arg) begin
				rows[r].arg = $urandom;
			end
		end
	endtask

	task automatic pulse_new_cmd();
		new_cmd = 1'b1;
		@(negedge CLK_host);
		new_cmd = 1'b0;
	endtask

	task automatic wait_for_result();
		while (cmd_complete !== 1'b1 && timeout_error !== 1'b1) begin
			@(negedge CLK_host);
		end
	endtask

	// Drops cmd_enable once the frame is out, while the master waits for a response
	task automatic disable_mid_command();
		int cycles;
		int bad_cycles;
		while (cmd_oe !== 1'b1) @(negedge CLK_host);
		while (cmd_oe === 1'b1) @(negedge CLK_host);
		repeat (8) @(negedge CLK_host);
		cmd_enable = 1'b0;
		@(negedge CLK_host);
		bad_cycles = 0;
		for (cycles = 0; cycles < TIMEOUT_BITS * CLK_DIV; cycles++) begin
			if (cmd_busy !== 1'b0 || cmd_complete !== 1'b0 || timeout_error !== 1'b0) begin
				bad_cycles++;
			end
			if (cycles == 16) begin
				cmd_enable = 1'b1;
			end
			@(negedge CLK_host);
		end
		if (bad_cycles != 0) begin
			report_mismatch($sformatf("busy or result seen on %0d cycles after disable",
				bad_cycles));
		end
	endtask

	task automatic run_row(input int r);
		int errors_before;
		int seen_before;
		int bad_before;
		logic [31:0] expect_status;
		errors_before = error_count;
		seen_before = frames_seen;
		bad_before = frames_bad;
		expect_status = rows[r].expect_complete ? rows[r].arg ^ STATUS_MASK : 32'h0;
		@(negedge CLK_host);
		exp_index = rows[r].index;
		exp_arg = rows[r].arg;
		reply_en = rows[r].reply;
		reply_delay = rows[r].delay;
		corrupt = rows[r].corrupt;
		cmd_index = rows[r].index;
		cmd_arg = rows[r].arg;
		pulse_new_cmd();
		if (cmd_busy !== 1'b1) begin
			report_mismatch($sformatf("row %0d cmd_busy low after new_cmd", r));
		end
		if (rows[r].restrobe) begin
			// Different word on a second strobe, which must be dropped
			repeat (3) @(negedge CLK_host);
			cmd_index = ~rows[r].index;
			cmd_arg = ~rows[r].arg;
			pulse_new_cmd();
		end
		if (rows[r].enable_held) begin
			wait_for_result();
			if (cmd_complete !== rows[r].expect_complete) begin
				report_mismatch($sformatf("row %0d cmd_complete %b, expected %b",
					r, cmd_complete, rows[r].expect_complete));
			end
			if (timeout_error !== !rows[r].expect_complete) begin
				report_mismatch($sformatf("row %0d timeout_error %b, expected %b",
					r, timeout_error, !rows[r].expect_complete));
			end
			if (response_status !== expect_status) begin
				report_mismatch($sformatf("row %0d response_status %08h, expected %08h",
					r, response_status, expect_status));
			end
			@(negedge CLK_host);
			if (cmd_complete !== 1'b0 || timeout_error !== 1'b0 || cmd_busy !== 1'b0) begin
				report_mismatch($sformatf("row %0d result not a single cycle", r));
			end
		end else begin
			disable_mid_command();
		end
		if (frames_seen - seen_before != 1) begin
			report_mismatch($sformatf("row %0d card saw %0d frames, expected 1",
				r, frames_seen - seen_before));
		end
		if (frames_bad != bad_before) begin
			report_mismatch($sformatf("row %0d transmitted frame has wrong fields", r));
		end
		tests_run++;
		if (error_count != errors_before) begin
			tests_failed++;
		end
		$display("row %0d index %0d arg %08h: %s", r, rows[r].index, rows[r].arg,
			(error_count == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		seed_value = $urandom(SEED);
		rst = 1'b1;
		cmd_enable = 1'b1;
		new_cmd = 1'b0;
		cmd_index = '0;
		cmd_arg = '0;
		exp_index = '0;
		exp_arg = '0;
		reply_en = 1'b0;
		reply_delay = 0;
		corrupt = 1'b0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		load_table();
		repeat (8) @(posedge CLK_host);
		@(negedge CLK_host);
		rst = 1'b0;
		if (cmd_busy !== 1'b0 || cmd_complete !== 1'b0 || timeout_error !== 1'b0 ||
			cmd_oe !== 1'b0 || cmd_out !== 1'b1) begin
			report_mismatch("outputs not at idle values after reset");
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
			repeat (4) @(negedge CLK_host);
		end
		$display("%0d rows run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
src/sd_cmd_pkg.sv
src/cmd_crc7.sv
src/cmd_response_rx.sv
src/cmd_physical.sv
src/cmd_master.sv
src/sd_cmd_top.sv
verification/sd_card_model.sv
verification/sd_cmd_sva.sv
verification/sd_cmd_tb.sv

// File: Bender.yml
package:
  name: sd_cmd

sources:
  - src/sd_cmd_pkg.sv
  - src/cmd_crc7.sv
  - src/cmd_response_rx.sv
  - src/cmd_physical.sv
  - src/cmd_master.sv
  - src/sd_cmd_top.sv
  - target: simulation
    files:
      - verification/sd_card_model.sv
      - verification/sd_cmd_sva.sv
      - verification/sd_cmd_tb.sv
